// File: design/gf_defines.svh
`ifndef GF_DEFINES_SVH
`define GF_DEFINES_SVH

// Field degree m. gf_pkg knows the field polynomials for 4 to 10.
`define GF_M 8

// Width of the divider's LFSR step counter, enough for m up to 15.
`define GF_CNT_W 4

`endif

// File: design/gf_pkg.sv
`include "gf_defines.svh"

package gf_pkg;

	typedef logic [`GF_M-1:0] gf_elem_t;	// One field element, standard or dual basis.

	// Field polynomial without the x^m term.
	function automatic gf_elem_t gf_poly();
		case (`GF_M)
			4: return gf_elem_t'(4'h3);	// x^4 + x + 1.
			5: return gf_elem_t'(5'h05);	// x^5 + x^2 + 1.
			6: return gf_elem_t'(6'h03);	// x^6 + x + 1.
			7: return gf_elem_t'(7'h03);	// x^7 + x + 1.
			8: return gf_elem_t'(8'h1d);	// x^8 + x^4 + x^3 + x^2 + 1.
			9: return gf_elem_t'(9'h011);	// x^9 + x^4 + 1.
			10: return gf_elem_t'(10'h009);	// x^10 + x^3 + 1.
			default: return '0;
		endcase
	endfunction

	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t x);
		return {x[`GF_M-2:0], 1'b0} ^ ({`GF_M{x[`GF_M-1]}} & gf_poly());
	endfunction

	// alpha^n in standard basis.
	function automatic gf_elem_t gf_lpow(input int n);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < n; i++)
			r = gf_mul_alpha(r);
		return r;
	endfunction

	// Dual coordinates are d[i] = f(alpha^i * x), with f taking the alpha^0 coefficient.
	function automatic gf_elem_t gf_std_to_dual(input gf_elem_t x);
		gf_elem_t t;
		gf_elem_t d;
		t = x;
		for (int i = 0; i < `GF_M; i++) begin
			d[i] = t[0];
			t = gf_mul_alpha(t);
		end
		return d;
	endfunction

	// The map above is triangular with a unit diagonal, so it inverts by substitution.
	function automatic gf_elem_t gf_dual_to_std(input gf_elem_t d);
		gf_elem_t x;
		gf_elem_t p;
		logic b;
		x = '0;
		x[0] = d[0];
		for (int i = 1; i < `GF_M; i++) begin
			b = d[i];
			for (int j = `GF_M - i + 1; j < `GF_M; j++) begin
				p = gf_lpow(i + j);
				b = b ^ (x[j] & p[0]);	// Terms of higher x bits already solved.
			end
			x[`GF_M-i] = b;
		end
		return x;
	endfunction

endpackage

// File: design/gf_pair_if.sv
`timescale 1ns/1ps

// Numerator/denominator pair handed from stage 1 to the divider.
interface gf_pair_if;
	import gf_pkg::*;

	logic valid;		// Stage 1 register holds a pair.
	gf_elem_t numer;	// a*b + c^3, standard basis.
	gf_elem_t denom;	// d, standard basis.
	logic take;		// Divider is idle.

	modport src (
		output valid, numer, denom,
		input take
	);

	modport dst (
		input valid, numer, denom,
		output take
	);
endinterface

// File: design/gf_mult_cube_stage.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

module gf_mult_cube_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input gf_pkg::gf_elem_t in_a,
	input gf_pkg::gf_elem_t in_b,
	input gf_pkg::gf_elem_t in_c,
	input gf_pkg::gf_elem_t in_d,
	output logic ready,
	gf_pair_if.src pair
);
	import gf_pkg::*;

	gf_elem_t prod_ab;
	gf_elem_t cube_c;
	logic load;

	// Bit-parallel standard basis product, one alpha row per bit of y.
	function automatic gf_elem_t std_mult(input gf_elem_t x, input gf_elem_t y);
		gf_elem_t row;
		gf_elem_t acc;
		row = x;
		acc = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (y[i])
				acc = acc ^ row;
			row = gf_mul_alpha(row);
		end
		return acc;
	endfunction

	// x^3 = sum x_i alpha^3i + sum over i<j of x_i x_j (alpha^(2i+j) + alpha^(i+2j))
	function automatic gf_elem_t cube(input gf_elem_t x);
		gf_elem_t acc;
		acc = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (x[i])
				acc = acc ^ gf_lpow(3 * i);
			for (int j = i + 1; j < `GF_M; j++) begin
				if (x[i] && x[j])
					acc = acc ^ gf_lpow(2 * i + j) ^ gf_lpow(i + 2 * j);
			end
		end
		return acc;
	endfunction

	assign prod_ab = std_mult(in_a, in_b);
	assign cube_c = cube(in_c);

	assign ready = !pair.valid || pair.take;	// Empty, or emptied this cycle.
	assign load = in_valid && ready;

	always_ff @(posedge clk) begin
		if (reset)
			pair.valid <= 1'b0;
		else if (load)
			pair.valid <= 1'b1;
		else if (pair.take)
			pair.valid <= 1'b0;	// Pair moved to the divider.
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pair.numer <= prod_ab ^ cube_c;
			pair.denom <= in_d;
		end
	end
endmodule

// File: design/gf_mixed_multiplier.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

// Berlekamp multiplier, dual basis times standard basis gives dual basis.
module gf_mixed_multiplier (
	input gf_pkg::gf_elem_t dual_in,
	input gf_pkg::gf_elem_t standard_in,
	output gf_pkg::gf_elem_t dual_out
);
	import gf_pkg::*;

	logic [2*`GF_M-2:0] ext;	// Dual coordinates of alpha^k * x, k = 0 to 2m-2.

	always_comb begin
		ext[`GF_M-1:0] = dual_in;
		for (int k = 0; k < `GF_M - 1; k++)
			ext[k+`GF_M] = ^(ext[k+:`GF_M] & gf_poly());	// LFSR extension.
		for (int i = 0; i < `GF_M; i++)
			dual_out[i] = ^(ext[i+:`GF_M] & standard_in);
	end
endmodule

// File: design/gf_fermat_divider.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

// q = numer * denom^(2^m-2), with denom^(2^m-2) = d^2 * d^4 * ... * d^(2^(m-1)).
module gf_fermat_divider (
	input logic clk,
	input logic reset,
	gf_pair_if.dst pair,
	output logic done,
	output gf_pkg::gf_elem_t q_dual
);
	import gf_pkg::*;

	localparam logic [`GF_CNT_W-1:0] CNT_TAPS = {{(`GF_CNT_W - 2){1'b0}}, 2'b11};	// x^4+x+1.
	localparam gf_elem_t ONE_DUAL = gf_std_to_dual(gf_elem_t'(1));

	function automatic logic [`GF_CNT_W-1:0] cnt_next(input logic [`GF_CNT_W-1:0] c);
		return {c[`GF_CNT_W-2:0], 1'b0} ^ ({`GF_CNT_W{c[`GF_CNT_W-1]}} & CNT_TAPS);
	endfunction

	// Counter state n steps after the start value.
	function automatic logic [`GF_CNT_W-1:0] cnt_after(input int n);
		logic [`GF_CNT_W-1:0] c;
		c = {{(`GF_CNT_W - 1){1'b0}}, 1'b1};
		for (int i = 0; i < n; i++)
			c = cnt_next(c);
		return c;
	endfunction

	// Squaring is linear, so it is a fixed XOR map.
	function automatic gf_elem_t square(input gf_elem_t x);
		gf_elem_t acc;
		acc = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (x[i])
				acc = acc ^ gf_lpow(2 * i);
		end
		return acc;
	endfunction

	localparam logic [`GF_CNT_W-1:0] CNT_START = cnt_after(0);
	localparam logic [`GF_CNT_W-1:0] CNT_LAST = cnt_after(`GF_M - 1);

	logic busy;
	logic start;
	logic last;
	logic [`GF_CNT_W-1:0] cnt;
	gf_elem_t sq_r;			// Next power d^(2^k) to accumulate.
	gf_elem_t numer_r;
	gf_elem_t acc_r;		// Running product, dual basis.
	gf_elem_t sq_next;
	gf_elem_t mult_std;
	gf_elem_t mult_out;

	assign pair.take = !busy;
	assign start = pair.valid && !busy;
	assign last = busy && (cnt == CNT_LAST);	// Numerator step.

	assign sq_next = square(busy ? sq_r : pair.denom);
	assign mult_std = last ? numer_r : sq_r;
	assign q_dual = acc_r;

	gf_mixed_multiplier u_mult (
		.dual_in(acc_r),
		.standard_in(mult_std),
		.dual_out(mult_out)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= CNT_START;
		end else begin
			done <= last;
			if (start) begin
				busy <= 1'b1;
				cnt <= CNT_START;
			end else if (busy) begin
				cnt <= cnt_next(cnt);
				if (last)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			numer_r <= pair.numer;
			acc_r <= ONE_DUAL;
		end else if (busy) begin
			acc_r <= mult_out;
		end
		if (start || busy)
			sq_r <= sq_next;
	end
endmodule

// File: design/gf_output_stage.sv
`timescale 1ns/1ps

module gf_output_stage (
	input logic clk,
	input logic reset,
	input logic done,
	input gf_pkg::gf_elem_t q_dual,
	output logic out_valid,
	output gf_pkg::gf_elem_t out_q
);
	import gf_pkg::*;

	gf_elem_t q_std;

	assign q_std = gf_dual_to_std(q_dual);	// Back to standard basis.

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= done;
	end

	always_ff @(posedge clk) begin
		if (done)
			out_q <= q_std;	// Quotient is stable while done is high.
	end
endmodule

// File: design/gf_eval_top.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

// q = (a*b + c^3) / d over GF(2^m), standard basis in and out.
module gf_eval_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [`GF_M-1:0] in_a,
	input logic [`GF_M-1:0] in_b,
	input logic [`GF_M-1:0] in_c,
	input logic [`GF_M-1:0] in_d,
	output logic ready,
	output logic out_valid,
	output logic [`GF_M-1:0] out_q
);
	import gf_pkg::*;

	logic div_done;
	gf_elem_t q_dual;

	gf_pair_if u_pair ();

	gf_mult_cube_stage u_stage1 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_a(in_a),
		.in_b(in_b),
		.in_c(in_c),
		.in_d(in_d),
		.ready(ready),
		.pair(u_pair)
	);

	gf_fermat_divider u_divider (
		.clk(clk),
		.reset(reset),
		.pair(u_pair),
		.done(div_done),
		.q_dual(q_dual)
	);

	gf_output_stage u_output (
		.clk(clk),
		.reset(reset),
		.done(div_done),
		.q_dual(q_dual),
		.out_valid(out_valid),
		.out_q(out_q)
	);
endmodule

// File: verification/gf_eval_ref.svh
`ifndef GF_EVAL_REF_SVH
`define GF_EVAL_REF_SVH

// Field polynomial including the x^m term.
function automatic int field_poly();
	case (`GF_M)
		4: return 'h13;
		5: return 'h25;
		6: return 'h43;
		7: return 'h83;
		8: return 'h11d;
		9: return 'h211;
		10: return 'h409;
		default: return 0;
	endcase
endfunction

// Shift and reduce multiply.
function automatic int ref_mul(input int x, input int y);
	int acc;
	int a;
	acc = 0;
	a = x;
	for (int i = 0; i < `GF_M; i++) begin
		if (y[i])
			acc = acc ^ a;
		a = a << 1;
		if (a[`GF_M])
			a = a ^ field_poly();	// Reduce the overflow bit.
	end
	return acc;
endfunction

// x^(2^m-2) as the product of x^2, x^4, ..., x^(2^(m-1)); zero stays zero.
function automatic int ref_inv(input int x);
	int r;
	int s;
	r = 1;
	s = x;
	for (int i = 1; i < `GF_M; i++) begin
		s = ref_mul(s, s);
		r = ref_mul(r, s);
	end
	return r;
endfunction

function automatic gf_elem_t eval_ref(input gf_elem_t a, input gf_elem_t b,
		input gf_elem_t c, input gf_elem_t d);
	int numer;
	numer = ref_mul(int'(a), int'(b)) ^ ref_mul(ref_mul(int'(c), int'(c)), int'(c));
	return gf_elem_t'(ref_mul(numer, ref_inv(int'(d))));
endfunction

`endif

// File: verification/gf_eval_tb.sv
`timescale 1ns/1ps
`include "gf_defines.svh"

module gf_eval_tb;
	import gf_pkg::*;

	`include "gf_eval_ref.svh"

	localparam int N_RANDOM = 200;
	localparam int N_ZERO = 16;
	localparam int N_CANCEL = 16;
	localparam int N_EDGE = 8;
	localparam int N_BURST = 60;
	localparam int N_OPS = N_RANDOM + N_ZERO + N_CANCEL + N_EDGE + N_BURST;
	localparam int TIMEOUT = N_OPS * (`GF_M + 4) + 100;

	logic clk;
	logic reset;
	logic in_valid;
	gf_elem_t in_a;
	gf_elem_t in_b;
	gf_elem_t in_c;
	gf_elem_t in_d;
	logic ready;
	logic out_valid;
	gf_elem_t out_q;

	int seed = 76;
	int cycles = 0;
	int n_accepted = 0;
	int burst_start;
	gf_elem_t c_val;
	gf_elem_t exp_q[$];	// Expected quotients in input order.

	gf_eval_top u_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_a(in_a),
		.in_b(in_b),
		.in_c(in_c),
		.in_d(in_d),
		.ready(ready),
		.out_valid(out_valid),
		.out_q(out_q)
	);

	always #4 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_elem(input string name, input gf_elem_t expected, input gf_elem_t actual);
		if (actual !== expected)
			report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_idle();
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("ready", 1'b1, ready);
	endtask

	function automatic gf_elem_t rand_elem();
		return gf_elem_t'($random(seed));
	endfunction

	// Present one set on the falling edge and hold it until it is taken.
	task automatic send_op(input gf_elem_t a, input gf_elem_t b, input gf_elem_t c, input gf_elem_t d);
		@(negedge clk);
		in_valid = 1'b1;
		in_a = a;
		in_b = b;
		in_c = c;
		in_d = d;
		while (!ready)
			@(negedge clk);
		@(posedge clk);	// Accepted here.
	endtask

	always @(posedge clk) begin
		if (!reset && in_valid && ready) begin
			exp_q.push_back(eval_ref(in_a, in_b, in_c, in_d));
			n_accepted++;
		end
	end

	always @(posedge clk) begin : compare_outputs
		gf_elem_t expected;
		if (!reset && out_valid) begin
			if (exp_q.size() == 0) begin
				report_failure("output without a pending input");
			end else begin
				expected = exp_q.pop_front();
				check_elem("out_q", expected, out_q);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT)
			report_failure("timeout reached while results were still missing");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_a = '0;
		in_b = '0;
		in_c = '0;
		in_d = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_idle();

		repeat (N_RANDOM)
			send_op(rand_elem(), rand_elem(), rand_elem(), rand_elem());
		repeat (N_ZERO)
			send_op(rand_elem(), rand_elem(), rand_elem(), '0);	// Quotient over zero is zero.
		repeat (N_CANCEL) begin
			c_val = rand_elem();
			send_op(c_val, gf_elem_t'(ref_mul(int'(c_val), int'(c_val))), c_val, rand_elem());
		end

		// Edge operands.
		send_op(rand_elem(), rand_elem(), rand_elem(), gf_elem_t'(1));
		send_op('0, rand_elem(), rand_elem(), rand_elem());
		send_op(rand_elem(), rand_elem(), '0, rand_elem());
		send_op('1, '1, '1, '1);
		send_op('0, rand_elem(), '0, rand_elem());
		send_op(rand_elem(), rand_elem(), '0, gf_elem_t'(1));
		send_op('1, '1, '1, gf_elem_t'(1));
		send_op('1, gf_elem_t'(1), '0, '1);

		// in_valid stays high; sets shown while ready is low must be dropped.
		@(negedge clk);
		burst_start = n_accepted;
		repeat (N_BURST) begin
			in_valid = 1'b1;
			in_a = rand_elem();
			in_b = rand_elem();
			in_c = rand_elem();
			in_d = rand_elem();
			@(negedge clk);
		end
		in_valid = 1'b0;
		// At most one take per M+1 cycles, plus the set left in stage 1.
		if (n_accepted - burst_start > N_BURST / (`GF_M + 1) + 2)
			report_failure("input presented while ready was low was accepted");

		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (`GF_M + 4) @(posedge clk);	// Catch any extra output.

		$display("NO ERRORS");
		$finish;
	end
endmodule

// File: verilog.f
+incdir+design
+incdir+verification
design/gf_pkg.sv
design/gf_pair_if.sv
design/gf_mult_cube_stage.sv
design/gf_mixed_multiplier.sv
design/gf_fermat_divider.sv
design/gf_output_stage.sv
design/gf_eval_top.sv
verification/gf_eval_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary -j 0 --top-module gf_eval_tb -f verilog.f -o gf_eval_sim

# The exit status of the simulation is not used here, the log decides.
./obj_dir/gf_eval_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "simulation did not complete"
	exit 1
fi
echo "simulation passed"
